// File: design/simple_sys_pkg.sv
/*
  simple system package: reduced TL-UL and device bus structs,
  opcodes, address map and memory sizes
*/
`default_nettype none

package simple_sys_pkg;

  // bus widths
  localparam int addr_w = 32;
  localparam int data_w = 32;
  localparam int mask_w = data_w / 8;
  localparam int src_w  = 4;

  // a-channel opcodes
  localparam logic [2:0] op_put_full    = 3'd0;
  localparam logic [2:0] op_put_partial = 3'd1;
  localparam logic [2:0] op_get         = 3'd4;

  // d-channel opcodes
  localparam logic [2:0] op_ack      = 3'd0;
  localparam logic [2:0] op_ack_data = 3'd1;

  // RAM window, 64 KB
  localparam logic [addr_w-1:0] ram_base  = 32'h0010_0000;
  localparam logic [addr_w-1:0] ram_bytes = 32'h0001_0000;
  localparam int ram_depth = int'(ram_bytes / mask_w);

  // simulator control window, 1 KB
  localparam logic [addr_w-1:0] simctrl_base     = 32'h0002_0000;
  localparam logic [addr_w-1:0] simctrl_bytes    = 32'h0000_0400;
  localparam logic [addr_w-1:0] simctrl_char_off = 32'h0000_0000;
  localparam logic [addr_w-1:0] simctrl_halt_off = 32'h0000_0008;

  // host to device
  typedef struct packed {
    logic              a_valid;
    logic [2:0]        a_opcode;
    logic [addr_w-1:0] a_address;
    logic [mask_w-1:0] a_mask;
    logic [data_w-1:0] a_data;
    logic [src_w-1:0]  a_source;
  } tl_a_t;

  // device to host
  typedef struct packed {
    logic              d_valid;
    logic [2:0]        d_opcode;
    logic [data_w-1:0] d_data;
    logic              d_error;
    logic [src_w-1:0]  d_source;
  } tl_d_t;

  // simple device request, answered one cycle later
  typedef struct packed {
    logic              req;
    logic              we;
    logic [mask_w-1:0] be;
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] wdata;
  } dev_req_t;

  typedef struct packed {
    logic              rvalid;
    logic [data_w-1:0] rdata;
  } dev_rsp_t;

endpackage

`default_nettype wire

// File: design/tlul_dev_adapter.sv
/*
  TL-UL device adapter: turns a-channel beats into single-cycle device
  requests and returns the device answer on the d-channel
*/
`timescale 1ns/1ps
`default_nettype none

module tlul_dev_adapter (
  input  wire                      clk_i,
  input  wire                      arst_n_i,
  input  simple_sys_pkg::tl_a_t    tl_a_i,
  output logic                     a_ready_o,
  output simple_sys_pkg::tl_d_t    tl_d_o,
  input  wire                      d_ready_i,
  output simple_sys_pkg::dev_req_t dev_req_o,
  input  simple_sys_pkg::dev_rsp_t dev_rsp_i
);

  import simple_sys_pkg::*;

  logic             a_fire;
  logic             pend_q;
  logic             pend_get_q;
  logic [src_w-1:0] pend_src_q;
  logic             hold_q;
  tl_d_t            hold_d_q;
  tl_d_t            live_d;

  // a new beat only when the d-channel is free or draining now
  assign a_ready_o = !tl_d_o.d_valid || d_ready_i;
  assign a_fire    = tl_a_i.a_valid && a_ready_o;

  assign dev_req_o.req   = a_fire;
  assign dev_req_o.we    = (tl_a_i.a_opcode != op_get);
  assign dev_req_o.be    = tl_a_i.a_mask;
  assign dev_req_o.addr  = tl_a_i.a_address;
  assign dev_req_o.wdata = tl_a_i.a_data;

  // device answer in the cycle after the request
  assign live_d.d_valid  = pend_q && dev_rsp_i.rvalid;
  assign live_d.d_opcode = pend_get_q ? op_ack_data : op_ack;
  assign live_d.d_data   = pend_get_q ? dev_rsp_i.rdata : '0;
  assign live_d.d_error  = 1'b0;
  assign live_d.d_source = pend_src_q;

  // held copy wins while the host stalls
  assign tl_d_o = hold_q ? hold_d_q : live_d;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pend_q <= 1'b0;
      hold_q <= 1'b0;
    end else begin
      pend_q <= a_fire;
      if (live_d.d_valid && !d_ready_i) begin
        hold_q <= 1'b1;
      end else if (hold_q && d_ready_i) begin
        hold_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_fire) begin
      pend_src_q <= tl_a_i.a_source;
      pend_get_q <= (tl_a_i.a_opcode == op_get);
    end
    if (live_d.d_valid && !d_ready_i) begin
      hold_d_q <= live_d;
    end
  end

  d_stable_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    tl_d_o.d_valid && !d_ready_i |=> $stable(tl_d_o));

endmodule

`default_nettype wire

// File: design/xbar_main.sv
/*
  main crossbar: routes the data host port to RAM or simulator control
  and answers unmapped addresses with an error response
*/
`timescale 1ns/1ps
`default_nettype none

module xbar_main (
  input  wire                   clk_i,
  input  wire                   arst_n_i,
  input  simple_sys_pkg::tl_a_t host_a_i,
  output logic                  host_a_ready_o,
  output simple_sys_pkg::tl_d_t host_d_o,
  input  wire                   host_d_ready_i,
  output simple_sys_pkg::tl_a_t ram_a_o,
  input  wire                   ram_a_ready_i,
  input  simple_sys_pkg::tl_d_t ram_d_i,
  output logic                  ram_d_ready_o,
  output simple_sys_pkg::tl_a_t simctrl_a_o,
  input  wire                   simctrl_a_ready_i,
  input  simple_sys_pkg::tl_d_t simctrl_d_i,
  output logic                  simctrl_d_ready_o
);

  import simple_sys_pkg::*;

  logic             sel_ram;
  logic             sel_sim;
  logic             host_d_free;
  logic             host_fire;
  // bit 0 RAM, bit 1 simctrl, zero for unmapped
  logic [1:0]       tgt_q;
  logic             err_valid_q;
  logic             err_get_q;
  logic [src_w-1:0] err_src_q;
  tl_d_t            err_d;

  assign sel_ram = (host_a_i.a_address & ~(ram_bytes - 32'd1)) == ram_base;
  assign sel_sim = (host_a_i.a_address & ~(simctrl_bytes - 32'd1)) == simctrl_base;

  // one response outstanding per port
  assign host_d_free = !host_d_o.d_valid || host_d_ready_i;

  always_comb begin
    ram_a_o             = host_a_i;
    ram_a_o.a_valid     = host_a_i.a_valid && sel_ram && host_d_free;
    simctrl_a_o         = host_a_i;
    simctrl_a_o.a_valid = host_a_i.a_valid && sel_sim && host_d_free;

    if (sel_ram) begin
      host_a_ready_o = host_d_free && ram_a_ready_i;
    end else if (sel_sim) begin
      host_a_ready_o = host_d_free && simctrl_a_ready_i;
    end else begin
      host_a_ready_o = host_d_free;
    end
  end

  assign host_fire = host_a_i.a_valid && host_a_ready_o;

  // locally generated error answer
  assign err_d.d_valid  = err_valid_q;
  assign err_d.d_opcode = err_get_q ? op_ack_data : op_ack;
  assign err_d.d_data   = '0;
  assign err_d.d_error  = 1'b1;
  assign err_d.d_source = err_src_q;

  // d-channel follows the target of the last beat
  always_comb begin
    case (tgt_q)
      2'b01:   host_d_o = ram_d_i;
      2'b10:   host_d_o = simctrl_d_i;
      default: host_d_o = err_d;
    endcase
  end

  assign ram_d_ready_o     = host_d_ready_i && (tgt_q == 2'b01);
  assign simctrl_d_ready_o = host_d_ready_i && (tgt_q == 2'b10);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      tgt_q       <= 2'b00;
      err_valid_q <= 1'b0;
    end else begin
      if (host_fire) begin
        tgt_q <= {sel_sim, sel_ram};
      end
      if (host_fire && !sel_ram && !sel_sim) begin
        err_valid_q <= 1'b1;
      end else if (host_d_ready_i) begin
        err_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (host_fire) begin
      err_src_q <= host_a_i.a_source;
      err_get_q <= (host_a_i.a_opcode == op_get);
    end
  end

  one_target_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(ram_a_o.a_valid && simctrl_a_o.a_valid));

endmodule

`default_nettype wire

// File: design/ram_2p.sv
/*
  dual-port word RAM: port A read/write with byte enables,
  port B read only, both answer one cycle after the request
*/
`timescale 1ns/1ps
`default_nettype none

module ram_2p #(
  parameter int depth = simple_sys_pkg::ram_depth
) (
  input  wire                      clk_i,
  input  simple_sys_pkg::dev_req_t a_req_i,
  output simple_sys_pkg::dev_rsp_t a_rsp_o,
  input  simple_sys_pkg::dev_req_t b_req_i,
  output simple_sys_pkg::dev_rsp_t b_rsp_o
);

  import simple_sys_pkg::*;

  localparam int idx_w = $clog2(depth);

  logic [data_w-1:0] mem [depth];
  logic [idx_w-1:0]  a_idx;
  logic [idx_w-1:0]  b_idx;

  // word index inside the window
  assign a_idx = a_req_i.addr[idx_w+1:2];
  assign b_idx = b_req_i.addr[idx_w+1:2];

  always_ff @(posedge clk_i) begin
    a_rsp_o.rvalid <= a_req_i.req;
    if (a_req_i.req) begin
      if (a_req_i.we) begin
        for (int i = 0; i < mask_w; i++) begin
          if (a_req_i.be[i]) begin
            mem[a_idx][8*i +: 8] <= a_req_i.wdata[8*i +: 8];
          end
        end
      end
      a_rsp_o.rdata <= mem[a_idx];
    end
  end

  // fetch port
  always_ff @(posedge clk_i) begin
    b_rsp_o.rvalid <= b_req_i.req;
    if (b_req_i.req) begin
      b_rsp_o.rdata <= mem[b_idx];
    end
  end

  a_addr_known_a: assert property (@(posedge clk_i) a_req_i.req |-> !$isunknown(a_req_i.addr));
  b_addr_known_a: assert property (@(posedge clk_i) b_req_i.req |-> !$isunknown(b_req_i.addr));

endmodule

`default_nettype wire

// File: design/sim_ctrl.sv
/*
  simulator control: character output register and sticky halt flag
*/
`timescale 1ns/1ps
`default_nettype none

module sim_ctrl (
  input  wire                      clk_i,
  input  wire                      arst_n_i,
  input  simple_sys_pkg::dev_req_t req_i,
  output simple_sys_pkg::dev_rsp_t rsp_o,
  output logic                     char_valid_o,
  output logic [7:0]               char_o,
  output logic                     halt_o
);

  import simple_sys_pkg::*;

  logic [addr_w-1:0] off;
  logic              char_sel;
  logic              halt_sel;
  logic              char_valid_q;
  logic [7:0]        char_q;
  logic              halt_q;
  logic              rvalid_q;
  logic [data_w-1:0] rdata_q;

  // offset within the 1 KB window
  assign off      = req_i.addr & (simctrl_bytes - 32'd1);
  assign char_sel = (off == simctrl_char_off);
  assign halt_sel = (off == simctrl_halt_off);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      char_valid_q <= 1'b0;
      char_q       <= '0;
      halt_q       <= 1'b0;
      rvalid_q     <= 1'b0;
    end else begin
      rvalid_q     <= req_i.req;
      char_valid_q <= req_i.req && req_i.we && char_sel;
      if (req_i.req && req_i.we && char_sel) begin
        char_q <= req_i.wdata[7:0];
      end
      // halt only clears on reset
      if (req_i.req && req_i.we && halt_sel && req_i.wdata[0]) begin
        halt_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      if (char_sel) begin
        rdata_q <= {{(data_w-8){1'b0}}, char_q};
      end else if (halt_sel) begin
        rdata_q <= {{(data_w-1){1'b0}}, halt_q};
      end else begin
        rdata_q <= '0;
      end
    end
  end

  assign rsp_o.rvalid = rvalid_q;
  assign rsp_o.rdata  = rdata_q;
  assign char_valid_o = char_valid_q;
  assign char_o       = char_q;
  assign halt_o       = halt_q;

endmodule

`default_nettype wire

// File: design/simple_system.sv
/*
  simple system top: crossbar, TL-UL adapters, dual-port RAM
  and simulator control behind a data and an instruction host port
*/
`timescale 1ns/1ps
`default_nettype none

module simple_system (
  input  wire                   clk_i,
  input  wire                   arst_n_i,
  input  simple_sys_pkg::tl_a_t data_a_i,
  output logic                  data_a_ready_o,
  output simple_sys_pkg::tl_d_t data_d_o,
  input  wire                   data_d_ready_i,
  input  simple_sys_pkg::tl_a_t instr_a_i,
  output logic                  instr_a_ready_o,
  output simple_sys_pkg::tl_d_t instr_d_o,
  input  wire                   instr_d_ready_i,
  output logic                  char_valid_o,
  output logic [7:0]            char_o,
  output logic                  halt_o
);

  import simple_sys_pkg::*;

  // crossbar to device adapters
  tl_a_t    ram_a;
  logic     ram_a_ready;
  tl_d_t    ram_d;
  logic     ram_d_ready;
  tl_a_t    simctrl_a;
  logic     simctrl_a_ready;
  tl_d_t    simctrl_d;
  logic     simctrl_d_ready;

  // adapters to devices
  dev_req_t ram_req;
  dev_rsp_t ram_rsp;
  dev_req_t fetch_req;
  dev_rsp_t fetch_rsp;
  dev_req_t simctrl_req;
  dev_rsp_t simctrl_rsp;

  xbar_main u_xbar (
    .clk_i             (clk_i),
    .arst_n_i          (arst_n_i),
    .host_a_i          (data_a_i),
    .host_a_ready_o    (data_a_ready_o),
    .host_d_o          (data_d_o),
    .host_d_ready_i    (data_d_ready_i),
    .ram_a_o           (ram_a),
    .ram_a_ready_i     (ram_a_ready),
    .ram_d_i           (ram_d),
    .ram_d_ready_o     (ram_d_ready),
    .simctrl_a_o       (simctrl_a),
    .simctrl_a_ready_i (simctrl_a_ready),
    .simctrl_d_i       (simctrl_d),
    .simctrl_d_ready_o (simctrl_d_ready)
  );

  tlul_dev_adapter u_ram_adapter (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .tl_a_i    (ram_a),
    .a_ready_o (ram_a_ready),
    .tl_d_o    (ram_d),
    .d_ready_i (ram_d_ready),
    .dev_req_o (ram_req),
    .dev_rsp_i (ram_rsp)
  );

  tlul_dev_adapter u_simctrl_adapter (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .tl_a_i    (simctrl_a),
    .a_ready_o (simctrl_a_ready),
    .tl_d_o    (simctrl_d),
    .d_ready_i (simctrl_d_ready),
    .dev_req_o (simctrl_req),
    .dev_rsp_i (simctrl_rsp)
  );

  // instruction port goes straight to RAM port B
  tlul_dev_adapter u_instr_adapter (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .tl_a_i    (instr_a_i),
    .a_ready_o (instr_a_ready_o),
    .tl_d_o    (instr_d_o),
    .d_ready_i (instr_d_ready_i),
    .dev_req_o (fetch_req),
    .dev_rsp_i (fetch_rsp)
  );

  ram_2p #(
    .depth (ram_depth)
  ) u_ram (
    .clk_i   (clk_i),
    .a_req_i (ram_req),
    .a_rsp_o (ram_rsp),
    .b_req_i (fetch_req),
    .b_rsp_o (fetch_rsp)
  );

  sim_ctrl u_sim_ctrl (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .req_i        (simctrl_req),
    .rsp_o        (simctrl_rsp),
    .char_valid_o (char_valid_o),
    .char_o       (char_o),
    .halt_o       (halt_o)
  );

endmodule

`default_nettype wire

// File: verif/tb_simple_system.sv
/*
  testbench for the simple system that drives random TL-UL traffic on
  both host ports and checks it against a byte-level memory model
*/
`timescale 1ns/1ps
`default_nettype none

module tb_simple_system;

  import simple_sys_pkg::*;

  localparam int n_pool  = 16;
  localparam int n_mix   = 200;
  localparam int n_fetch = 40;
  localparam int n_unmap = 20;
  // transactions in the whole run including 8 for characters and 4 for halt
  localparam int n_txns  = n_pool + n_mix + n_fetch + 2 * n_unmap + 12;
  localparam int cycles_per_txn = 20;

  logic       clk_i;
  logic       arst_n_i;
  tl_a_t      data_a;
  logic       data_a_ready;
  tl_d_t      data_d;
  logic       data_d_ready;
  tl_a_t      instr_a;
  logic       instr_a_ready;
  tl_d_t      instr_d;
  logic       instr_d_ready;
  logic       char_valid;
  logic [7:0] char_byte;
  logic       halt;

  int          seed = 32'h6c1e21df;
  logic [7:0]  mem_model [int unsigned];
  logic [31:0] pool [n_pool];
  logic [7:0]  chars_q [$];
  logic [7:0]  last_char;
  logic        halt_exp;

  simple_system dut_i (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .data_a_i        (data_a),
    .data_a_ready_o  (data_a_ready),
    .data_d_o        (data_d),
    .data_d_ready_i  (data_d_ready),
    .instr_a_i       (instr_a),
    .instr_a_ready_o (instr_a_ready),
    .instr_d_o       (instr_d),
    .instr_d_ready_i (instr_d_ready),
    .char_valid_o    (char_valid),
    .char_o          (char_byte),
    .halt_o          (halt)
  );

  always #5 clk_i = ~clk_i;

  // one entry per cycle with char_valid high
  always @(negedge clk_i) begin
    if (char_valid) begin
      chars_q.push_back(char_byte);
    end
  end

  initial begin
    repeat (n_txns * cycles_per_txn) @(posedge clk_i);
    $display("Timeout: the DUT did not finish %0d transactions in %0d cycles",
             n_txns, n_txns * cycles_per_txn);
    $display("Errors found");
    $fatal(1, "watchdog expired");
  end

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("Error at %0t: %s = %h, expected %h", $time, name, got, exp);
      $display("Errors found");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  function automatic logic [31:0] rand32();
    return $random(seed);
  endfunction

  function automatic logic in_window(input logic [31:0] a, input logic [31:0] base,
                                     input logic [31:0] size);
    return (a >= base) && (a - base < size);
  endfunction

  // model bytes assembled little endian
  function automatic logic [31:0] model_word(input logic [31:0] addr);
    logic [31:0] w;
    for (int i = 0; i < 4; i++) begin
      w[8*i +: 8] = mem_model[{addr[31:2], 2'b00} + 32'(i)];
    end
    return w;
  endfunction

  task automatic model_write(input logic [31:0] addr, input logic [3:0] mask,
                             input logic [31:0] wdata);
    for (int i = 0; i < 4; i++) begin
      if (mask[i]) begin
        mem_model[{addr[31:2], 2'b00} + 32'(i)] = wdata[8*i +: 8];
      end
    end
  endtask

  task automatic drive_port(input bit instr, input tl_a_t a, input logic rdy);
    if (instr) begin
      instr_a       = a;
      instr_d_ready = rdy;
    end else begin
      data_a       = a;
      data_d_ready = rdy;
    end
  endtask

  function automatic tl_d_t port_d(input bit instr);
    return instr ? instr_d : data_d;
  endfunction

  function automatic logic port_a_ready(input bit instr);
    return instr ? instr_a_ready : data_a_ready;
  endfunction

  // one beat and its response with d_ready randomly low to stall it
  task automatic run_txn(input bit instr, input logic [2:0] op, input logic [31:0] addr,
                         input logic [3:0] mask, input logic [31:0] wdata,
                         output tl_d_t rsp);
    tl_a_t       a;
    tl_d_t       d;
    tl_d_t       held;
    logic [31:0] r;
    logic [3:0]  src;
    logic        rdy;
    string       port;
    port = instr ? "instr" : "data";
    r = rand32();
    src = r[3:0];
    a.a_valid   = 1'b1;
    a.a_opcode  = op;
    a.a_address = addr;
    a.a_mask    = mask;
    a.a_data    = wdata;
    a.a_source  = src;
    drive_port(instr, a, r[4]);
    @(negedge clk_i);
    d = port_d(instr);
    check_value({port, "_a_ready"}, 64'(port_a_ready(instr)), 64'd1);
    // nothing may be left over from the previous transaction
    check_value({port, "_d.d_valid before beat"}, 64'(d.d_valid), 64'd0);
    @(posedge clk_i);
    #1;
    r = rand32();
    rdy = r[0];
    drive_port(instr, '0, rdy);
    @(negedge clk_i);
    held = port_d(instr);
    check_value({port, "_d.d_valid"}, 64'(held.d_valid), 64'd1);
    check_value({port, "_d.d_source"}, 64'(held.d_source), 64'(src));
    while (!rdy) begin
      @(posedge clk_i);
      #1;
      r = rand32();
      rdy = r[0];
      drive_port(instr, '0, rdy);
      @(negedge clk_i);
      check_value({port, "_d while stalled"}, 64'(port_d(instr)), 64'(held));
    end
    @(posedge clk_i);
    #1;
    rsp = held;
  endtask

  task automatic expect_rsp(input tl_d_t d, input logic [2:0] op, input logic [31:0] data,
                            input logic err);
    check_value("d_opcode", 64'(d.d_opcode), 64'(op));
    check_value("d_data", 64'(d.d_data), 64'(data));
    check_value("d_error", 64'(d.d_error), 64'(err));
  endtask

  task automatic ram_access(input bit instr, input bit write, input logic [31:0] addr,
                            input logic [3:0] mask, input logic [31:0] wdata);
    tl_d_t      d;
    logic [2:0] op;
    if (!write) begin
      op = op_get;
    end else if (mask == 4'hf) begin
      op = op_put_full;
    end else begin
      op = op_put_partial;
    end
    run_txn(instr, op, addr, mask, wdata, d);
    if (write) begin
      model_write(addr, mask, wdata);
      expect_rsp(d, op_ack, 32'd0, 1'b0);
    end else begin
      expect_rsp(d, op_ack_data, model_word(addr), 1'b0);
    end
  endtask

  initial begin
    tl_d_t       d;
    logic [31:0] r;
    logic [31:0] addr;
    logic [3:0]  mask;
    clk_i         = 1'b0;
    arst_n_i      = 1'b0;
    data_a        = '0;
    data_d_ready  = 1'b0;
    instr_a       = '0;
    instr_d_ready = 1'b0;
    last_char     = 8'd0;
    halt_exp      = 1'b0;
    repeat (2) @(posedge clk_i);
    #1;
    arst_n_i = 1'b1;
    @(negedge clk_i);
    check_value("data_d.d_valid", 64'(data_d.d_valid), 64'd0);
    check_value("instr_d.d_valid", 64'(instr_d.d_valid), 64'd0);
    check_value("data_a_ready", 64'(data_a_ready), 64'd1);
    check_value("instr_a_ready", 64'(instr_a_ready), 64'd1);
    check_value("char_valid_o", 64'(char_valid), 64'd0);
    check_value("halt_o", 64'(halt), 64'(halt_exp));
    @(posedge clk_i);
    #1;

    // known contents first so every later read hits written bytes
    for (int k = 0; k < n_pool; k++) begin
      r = rand32();
      pool[k] = ram_base + {16'd0, r[15:2], 2'b00};
      ram_access(1'b0, 1'b1, pool[k], 4'hf, rand32());
    end

    for (int n = 0; n < n_mix; n++) begin
      r = rand32();
      addr = pool[r[7:4]];
      mask = (r[3:0] == 4'h0) ? 4'h1 : r[3:0];
      ram_access(1'b0, r[8], addr, r[8] ? mask : 4'hf, rand32());
    end

    // fetches see what the data port wrote
    for (int n = 0; n < n_fetch; n++) begin
      r = rand32();
      ram_access(1'b1, 1'b0, pool[r[3:0]], 4'hf, 32'd0);
    end

    for (int n = 0; n < 4; n++) begin
      r = rand32();
      chars_q.delete();
      run_txn(1'b0, op_put_full, simctrl_base + simctrl_char_off, 4'hf, r, d);
      last_char = r[7:0];
      expect_rsp(d, op_ack, 32'd0, 1'b0);
      check_value("char_valid_o pulse count", 64'(chars_q.size()), 64'd1);
      check_value("char_o", 64'(chars_q[0]), 64'(last_char));
      run_txn(1'b0, op_get, simctrl_base + simctrl_char_off, 4'hf, 32'd0, d);
      expect_rsp(d, op_ack_data, {24'd0, last_char}, 1'b0);
      // a read emits no character
      check_value("char_valid_o pulse count after read", 64'(chars_q.size()), 64'd1);
    end

    // halt is sticky
    run_txn(1'b0, op_put_full, simctrl_base + simctrl_halt_off, 4'hf, 32'd1, d);
    halt_exp = 1'b1;
    expect_rsp(d, op_ack, 32'd0, 1'b0);
    check_value("halt_o", 64'(halt), 64'(halt_exp));
    run_txn(1'b0, op_put_full, simctrl_base + simctrl_halt_off, 4'hf, 32'd0, d);
    expect_rsp(d, op_ack, 32'd0, 1'b0);
    check_value("halt_o", 64'(halt), 64'(halt_exp));
    run_txn(1'b0, op_get, simctrl_base + simctrl_halt_off, 4'hf, 32'd0, d);
    expect_rsp(d, op_ack_data, {31'd0, halt_exp}, 1'b0);
    run_txn(1'b0, op_get, simctrl_base + 32'h4, 4'hf, 32'd0, d);
    expect_rsp(d, op_ack_data, 32'd0, 1'b0);

    for (int n = 0; n < n_unmap; n++) begin
      addr = rand32();
      while (in_window(addr, ram_base, ram_bytes) ||
             in_window(addr, simctrl_base, simctrl_bytes)) begin
        addr = rand32();
      end
      r = rand32();
      run_txn(1'b0, r[0] ? op_get : op_put_full, addr, 4'hf, rand32(), d);
      expect_rsp(d, r[0] ? op_ack_data : op_ack, 32'd0, 1'b1);
      ram_access(1'b0, 1'b0, pool[r[4:1]], 4'hf, 32'd0);
    end

    $display("No errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: simple_system.f
design/simple_sys_pkg.sv
design/tlul_dev_adapter.sv
design/xbar_main.sv
design/ram_2p.sv
design/sim_ctrl.sv
design/simple_system.sv
verif/tb_simple_system.sv

// File: Makefile
# Verilator build and run of the simple system testbench

TOP := tb_simple_system

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check sim.log"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

obj_dir/V$(TOP): simple_system.f design/*.sv verif/*.sv
	verilator --binary --timing --assert --top-module $(TOP) \
		-f simple_system.f -Mdir obj_dir -o V$(TOP)

test: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -qx "No errors" sim.log; then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
